//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 --assert
PASS_TEXT ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_program_table.svh
// Program words per test, each closed by a JAL to itself, and the store stream
// that must come out on the data port, in order

typedef struct packed {
  word_t addr;
  word_t data;
  logic  use_load;
  word_t load_addr;
} store_exp_t;

string      prog_name[$];
int         prog_first[$];
int         prog_count[$];
inst_t      prog_words[$];
int         store_first[$];
int         store_count[$];
store_exp_t stores[$];

task automatic open_program(input string name);
  prog_name.push_back(name);
  prog_first.push_back(prog_words.size());
  prog_count.push_back(0);
  store_first.push_back(stores.size());
  store_count.push_back(0);
endtask

task automatic emit(input inst_t word);
  prog_words.push_back(word);
  prog_count[prog_count.size()-1] += 1;
endtask

// Data is added to the random word at load_addr when use_load is set
task automatic expect_store(input int addr, input int data, input logic use_load,
                            input int load_addr);
  store_exp_t entry;
  entry.addr      = word_t'(addr);
  entry.data      = word_t'(data);
  entry.use_load  = use_load;
  entry.load_addr = word_t'(load_addr);
  stores.push_back(entry);
  store_count[store_count.size()-1] += 1;
endtask

// Not-taken branch over one good store, then a taken one over two bad stores
task automatic branch_pair(input int f3, input int nt_a, input int nt_b,
                           input int t_a, input int t_b, input int good_addr);
  emit(b_type(f3, nt_a, nt_b, 8));
  emit(s_type(0, 5, good_addr));
  expect_store(good_addr, 'h55, 1'b0, 0);
  emit(b_type(f3, t_a, t_b, 12));
  emit(s_type(0, 6, 'h2F0));
  emit(s_type(0, 6, 'h2F4));
endtask

task automatic build_program_table();
  open_program("alu chain");
  emit(i_type(OPC_IMM, 0, 1, 0, 5));
  emit(i_type(OPC_IMM, 0, 2, 1, -3));
  emit(r_type('h00, 0, 3, 1, 2));
  emit(r_type('h20, 0, 4, 3, 1));
  emit(u_type(OPC_LUI, 5, 'h12345));
  emit(i_type(OPC_IMM, 0, 5, 5, 'h678));
  emit(r_type('h00, 4, 6, 5, 3));
  emit(s_type(0, 6, 'h200));
  emit(u_type(OPC_LUI, 7, 'h80000));
  emit(i_type(OPC_IMM, 5, 8, 7, 'h404));
  emit(r_type('h00, 5, 9, 8, 4));
  emit(r_type('h00, 2, 10, 8, 1));
  emit(r_type('h00, 3, 11, 8, 1));
  emit(r_type('h00, 6, 12, 10, 9));
  emit(r_type('h00, 1, 13, 1, 4));
  emit(u_type(OPC_AUIPC, 14, 'h00001));
  emit(s_type(0, 12, 'h204));
  emit(s_type(0, 11, 'h208));
  emit(s_type(0, 13, 'h20C));
  emit(s_type(0, 14, 'h210));
  // x0 keeps reading zero after a write
  emit(i_type(OPC_IMM, 0, 0, 1, 7));
  emit(s_type(0, 0, 'h214));
  emit(i_type(OPC_IMM, 7, 15, 5, 'h0FF));
  emit(i_type(OPC_IMM, 4, 16, 15, -1));
  emit(r_type('h20, 5, 17, 16, 4));
  emit(s_type(0, 17, 'h218));
  emit(j_type(0, 0));
  expect_store('h200, 'h1234567F, 1'b0, 0);
  expect_store('h204, 'h3E000001, 1'b0, 0);
  expect_store('h208, 'h00000000, 1'b0, 0);
  expect_store('h20C, 'h00000014, 1'b0, 0);
  expect_store('h210, 'h0000103C, 1'b0, 0);
  expect_store('h214, 'h00000000, 1'b0, 0);
  expect_store('h218, 'hFFFFFFE1, 1'b0, 0);

  open_program("load use");
  emit(i_type(OPC_IMM, 0, 1, 0, 'h010));
  emit(i_type(OPC_LOAD, 2, 2, 1, 4));
  emit(i_type(OPC_IMM, 0, 3, 2, 'h123));
  emit(s_type(0, 3, 'h240));
  emit(i_type(OPC_LOAD, 2, 4, 0, 'h020));
  emit(r_type('h00, 0, 5, 1, 4));
  emit(s_type(0, 5, 'h244));
  emit(i_type(OPC_LOAD, 2, 6, 0, 'h030));
  emit(s_type(0, 6, 'h248));
  emit(j_type(0, 0));
  expect_store('h240, 'h123, 1'b1, 'h014);
  expect_store('h244, 'h010, 1'b1, 'h020);
  expect_store('h248, 'h000, 1'b1, 'h030);

  // x1 is -1, x2 and x3 are 1
  open_program("branches");
  emit(i_type(OPC_IMM, 0, 1, 0, -1));
  emit(i_type(OPC_IMM, 0, 2, 0, 1));
  emit(i_type(OPC_IMM, 0, 3, 0, 1));
  emit(i_type(OPC_IMM, 0, 5, 0, 'h055));
  emit(i_type(OPC_IMM, 0, 6, 0, 'h066));
  branch_pair(0, 1, 2, 2, 3, 'h260);
  branch_pair(1, 2, 3, 1, 2, 'h268);
  branch_pair(4, 2, 1, 1, 2, 'h270);
  branch_pair(5, 1, 2, 2, 1, 'h278);
  branch_pair(6, 1, 2, 2, 1, 'h280);
  branch_pair(7, 2, 1, 1, 2, 'h288);
  emit(s_type(0, 5, 'h290));
  expect_store('h290, 'h55, 1'b0, 0);
  emit(j_type(0, 0));

  // JALR target 0x21 lands on 0x20 with bit 0 cleared
  open_program("jumps");
  emit(i_type(OPC_IMM, 0, 1, 0, 'h01F));
  emit(j_type(2, 12));
  emit(s_type(0, 0, 'h2F0));
  emit(s_type(0, 0, 'h2F4));
  emit(s_type(0, 2, 'h2A0));
  emit(i_type(OPC_JALR, 0, 3, 1, 2));
  emit(s_type(0, 0, 'h2F0));
  emit(s_type(0, 0, 'h2F4));
  emit(s_type(0, 3, 'h2A4));
  emit(j_type(0, 0));
  expect_store('h2A0, 'h08, 1'b0, 0);
  expect_store('h2A4, 'h18, 1'b0, 0);
endtask

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_core_pkg::*;
;

  localparam int    IMEM_AW       = 8;
  localparam int    DMEM_AW       = 8;
  localparam int    IMEM_WORDS    = 1 << IMEM_AW;
  localparam int    DMEM_WORDS    = 1 << DMEM_AW;
  localparam int    RESET_CYCLES  = 5;
  localparam int    STORE_TIMEOUT = 200;
  localparam word_t START_PC      = '0;

  // RV32I major opcodes used by the I and U formats
  localparam int OPC_LOAD  = 'h03;
  localparam int OPC_IMM   = 'h13;
  localparam int OPC_AUIPC = 'h17;
  localparam int OPC_LUI   = 'h37;
  localparam int OPC_JALR  = 'h67;

  logic      clk = 1'b0;
  logic      rst_n;
  word_t     imem_addr;
  inst_t     imem_rdata;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  inst_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];

  rv_core_top #(
    .RESET_PC(START_PC)
  ) rv_core_top_inst (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_req   (dmem_req),
    .i_dmem_rdata (dmem_rdata)
  );

  always #10 clk = ~clk;

  // Both memories answer combinationally
  assign imem_rdata = imem[imem_addr[IMEM_AW+1:2]];
  assign dmem_rdata = dmem[dmem_req.addr[DMEM_AW+1:2]];

  // Data memory with seeded random contents
  // A store seen before the rising edge is written just after it
  initial begin
    dmem_req_t req;
    void'($urandom(96));
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = $urandom();
    end
    forever begin
      @(negedge clk);
      req = dmem_req;
      @(posedge clk);
      #1;
      if (req.we) begin
        dmem[req.addr[DMEM_AW+1:2]] = req.wdata;
      end
    end
  end

  // Instruction encoders for the RV32I formats
  function automatic inst_t r_type(input int f7, input int f3, input int rd,
                                   input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic inst_t i_type(input int op, input int f3, input int rd,
                                   input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic inst_t s_type(input int rs1, input int rs2, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t b_type(input int f3, input int rs1, input int rs2,
                                   input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
  endfunction

  function automatic inst_t u_type(input int op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic inst_t j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  `include "tb_program_table.svh"

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("error: %s got 0x%08h expected 0x%08h", name, got, want);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, want);
      abort_run();
    end
  endtask

  // Words past the program have a zero opcode and decode as bubbles
  task automatic load_imem(input int p);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {i[24:0], 7'h00};
    end
    for (int k = 0; k < prog_count[p]; k++) begin
      imem[k] = prog_words[prog_first[p] + k];
    end
  endtask

  task automatic reset_core(input int p);
    @(posedge clk);
    #1 rst_n = 1'b0;
    load_imem(p);
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_flag("o_dmem_req.we", dmem_req.we, 1'b0);
      check_word("o_imem_addr", imem_addr, START_PC);
    end
    @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  // Store strobe is polled on each falling edge
  task automatic wait_store(input int p, input int s);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!dmem_req.we) begin
      cycles++;
      if (cycles >= STORE_TIMEOUT) begin
        $display("Store %0d of program '%s' never came within %0d cycles",
                 s, prog_name[p], STORE_TIMEOUT);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic run_program(input int p);
    store_exp_t want;
    word_t      want_data;
    reset_core(p);
    for (int s = 0; s < store_count[p]; s++) begin
      want = stores[store_first[p] + s];
      wait_store(p, s);
      want_data = want.data;
      if (want.use_load) begin
        want_data = want_data + dmem[want.load_addr[DMEM_AW+1:2]];
      end
      check_word("o_dmem_req.addr", dmem_req.addr, want.addr);
      check_word("o_dmem_req.wdata", dmem_req.wdata, want_data);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    build_program_table();
    load_imem(0);
    for (int p = 0; p < prog_name.size(); p++) begin
      run_program(p);
    end
    $display("Test OK");
    $finish;
  end

endmodule

//--- files.f
+incdir+bench
hw/rv_core_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/hazard_unit.sv
hw/rv_core_top.sv
bench/tb_rv_core.sv

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import rv_core_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  if_id_t    i_if_id,
  input  logic      i_stall,
  input  logic      i_redirect,
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  input  word_t     i_rs1_data,
  input  word_t     i_rs2_data,
  output id_ex_t    o_id_ex
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  inst_t      inst;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t      imm;
  logic       legal, use_rs1, use_rs2;
  logic       reg_we, mem_read, mem_write;
  alu_op_e    alu_op;
  alu_a_sel_e a_sel;
  alu_b_sel_e b_sel;
  br_op_e     br_op;
  wb_sel_e    wb_sel;

  // funct3 to ALU operation, alt picks SUB or SRA
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign inst   = i_if_id.inst;
  assign funct3 = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    legal     = 1'b1;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    reg_we    = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_op    = ALU_ADD;
    a_sel     = A_RS1;
    b_sel     = B_IMM;
    br_op     = BR_NONE;
    wb_sel    = WB_ALU;
    imm       = imm_i;
    case (inst[6:0])
      OP_LUI: begin
        reg_we = 1'b1;
        alu_op = ALU_PASS_B;
        imm    = imm_u;
      end
      OP_AUIPC: begin
        reg_we = 1'b1;
        a_sel  = A_PC;
        imm    = imm_u;
      end
      OP_JAL: begin
        reg_we = 1'b1;
        a_sel  = A_PC;
        imm    = imm_j;
        br_op  = BR_JUMP;
        wb_sel = WB_PC4;
      end
      OP_JALR: begin
        reg_we  = 1'b1;
        use_rs1 = 1'b1;
        br_op   = BR_JUMP;
        wb_sel  = WB_PC4;
      end
      OP_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        a_sel   = A_PC;
        imm     = imm_b;
        case (funct3)
          3'b000:  br_op = BR_EQ;
          3'b001:  br_op = BR_NE;
          3'b100:  br_op = BR_LT;
          3'b101:  br_op = BR_GE;
          3'b110:  br_op = BR_LTU;
          3'b111:  br_op = BR_GEU;
          default: legal = 1'b0;
        endcase
      end
      OP_LOAD: begin
        // Word loads only
        legal    = (funct3 == 3'b010);
        reg_we   = 1'b1;
        mem_read = 1'b1;
        use_rs1  = 1'b1;
        wb_sel   = WB_LOAD;
      end
      OP_STORE: begin
        legal     = (funct3 == 3'b010);
        mem_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        imm       = imm_s;
      end
      OP_IMM: begin
        reg_we  = 1'b1;
        use_rs1 = 1'b1;
        alu_op  = alu_from_f3(funct3, (funct3 == 3'b101) && inst[30]);
      end
      OP_REG: begin
        // funct7 bit 0 set means M extension, not supported
        legal   = !inst[25];
        reg_we  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        b_sel   = B_RS2;
        alu_op  = alu_from_f3(funct3, inst[30]);
      end
      default: legal = 1'b0;
    endcase
  end

  // Unused source fields read as x0 so they never match a hazard
  assign o_rs1_addr = (i_if_id.valid && use_rs1) ? inst[19:15] : '0;
  assign o_rs2_addr = (i_if_id.valid && use_rs2) ? inst[24:20] : '0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_id_ex <= '0;
    end else if (i_redirect || i_stall) begin
      o_id_ex <= '0;
    end else begin
      o_id_ex.valid     <= i_if_id.valid && legal;
      o_id_ex.pc        <= i_if_id.pc;
      o_id_ex.rs1_val   <= i_rs1_data;
      o_id_ex.rs2_val   <= i_rs2_data;
      o_id_ex.imm       <= imm;
      o_id_ex.rs1       <= o_rs1_addr;
      o_id_ex.rs2       <= o_rs2_addr;
      o_id_ex.rd        <= reg_we ? inst[11:7] : '0;
      o_id_ex.reg_we    <= reg_we && legal;
      o_id_ex.mem_read  <= mem_read && legal;
      o_id_ex.mem_write <= mem_write && legal;
      o_id_ex.alu_op    <= alu_op;
      o_id_ex.a_sel     <= a_sel;
      o_id_ex.b_sel     <= b_sel;
      o_id_ex.br_op     <= br_op;
      o_id_ex.wb_sel    <= wb_sel;
    end
  end

  // Load-use stall only ever holds behind a load, and lasts one cycle
  a_stall_on_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_stall |-> o_id_ex.valid && o_id_ex.mem_read);
  a_stall_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_stall |=> !i_stall);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import rv_core_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  id_ex_t   i_id_ex,
  input  fwd_sel_e i_fwd_a,
  input  fwd_sel_e i_fwd_b,
  input  word_t    i_mem_fwd,
  input  word_t    i_wb_fwd,
  output logic     o_redirect,
  output word_t    o_target,
  output ex_mem_t  o_ex_mem
);

  word_t      rs1_fwd, rs2_fwd;
  word_t      op_a, op_b;
  word_t      alu_result;
  logic [4:0] shamt;
  logic       eq, lt, ltu;
  logic       take;

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign rs1_fwd = fwd_mux(i_fwd_a, i_id_ex.rs1_val, i_mem_fwd, i_wb_fwd);
  assign rs2_fwd = fwd_mux(i_fwd_b, i_id_ex.rs2_val, i_mem_fwd, i_wb_fwd);

  assign op_a  = (i_id_ex.a_sel == A_PC) ? i_id_ex.pc : rs1_fwd;
  assign op_b  = (i_id_ex.b_sel == B_IMM) ? i_id_ex.imm : rs2_fwd;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_id_ex.alu_op)
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // Branch compare always works on the forwarded register values
  assign eq  = (rs1_fwd == rs2_fwd);
  assign lt  = ($signed(rs1_fwd) < $signed(rs2_fwd));
  assign ltu = (rs1_fwd < rs2_fwd);

  always_comb begin
    case (i_id_ex.br_op)
      BR_EQ:   take = eq;
      BR_NE:   take = !eq;
      BR_LT:   take = lt;
      BR_GE:   take = !lt;
      BR_LTU:  take = ltu;
      BR_GEU:  take = !ltu;
      BR_JUMP: take = 1'b1;
      default: take = 1'b0;
    endcase
  end

  assign o_redirect = i_id_ex.valid && take;

  // JALR is the only jump with rs1 as base
  assign o_target = {alu_result[XLEN-1:1],
                     alu_result[0] & !(i_id_ex.br_op == BR_JUMP && i_id_ex.a_sel == A_RS1)};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ex_mem <= '0;
    end else begin
      o_ex_mem.valid      <= i_id_ex.valid;
      o_ex_mem.alu_result <= alu_result;
      o_ex_mem.store_data <= rs2_fwd;
      o_ex_mem.pc4        <= i_id_ex.pc + word_t'(4);
      o_ex_mem.rd         <= i_id_ex.rd;
      o_ex_mem.reg_we     <= i_id_ex.reg_we;
      o_ex_mem.mem_read   <= i_id_ex.mem_read;
      o_ex_mem.mem_write  <= i_id_ex.mem_write;
      o_ex_mem.wb_sel     <= i_id_ex.wb_sel;
    end
  end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_stall,
  input  logic   i_redirect,
  input  word_t  i_target,
  output word_t  o_imem_addr,
  input  inst_t  i_imem_rdata,
  output if_id_t o_if_id
);

  word_t pc;

  assign o_imem_addr = pc;

  // Redirect wins over stall
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc      <= RESET_PC;
      o_if_id <= '0;
    end else if (i_redirect) begin
      pc            <= i_target;
      o_if_id.valid <= 1'b0;
    end else if (!i_stall) begin
      pc            <= pc + word_t'(4);
      o_if_id.valid <= 1'b1;
      o_if_id.pc    <= pc;
      o_if_id.inst  <= i_imem_rdata;
    end
  end

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
  import rv_core_pkg::*;
(
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  input  id_ex_t    i_id_ex,
  input  ex_mem_t   i_ex_mem,
  input  logic      i_wb_we,
  input  reg_addr_t i_wb_rd,
  output logic      o_stall,
  output fwd_sel_e  o_fwd_a,
  output fwd_sel_e  o_fwd_b
);

  logic load_in_ex;

  // Memory stage first, it holds the younger result
  function automatic fwd_sel_e pick_fwd(input reg_addr_t rs, input ex_mem_t em,
                                        input logic wb_we, input reg_addr_t wb_rd);
    if (rs == '0) begin
      return FWD_NONE;
    end
    if (em.valid && em.reg_we && !em.mem_read && em.rd == rs) begin
      return FWD_MEM;
    end
    if (wb_we && wb_rd == rs) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign load_in_ex = i_id_ex.valid && i_id_ex.mem_read && (i_id_ex.rd != '0);

  // Hold decode one cycle behind a load it depends on
  assign o_stall = load_in_ex &&
                   (i_id_ex.rd == i_rs1_addr || i_id_ex.rd == i_rs2_addr);

  assign o_fwd_a = pick_fwd(i_id_ex.rs1, i_ex_mem, i_wb_we, i_wb_rd);
  assign o_fwd_b = pick_fwd(i_id_ex.rs2, i_ex_mem, i_wb_we, i_wb_rd);

endmodule

//--- hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
  import rv_core_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  ex_mem_t   i_ex_mem,
  output dmem_req_t o_dmem_req,
  input  word_t     i_dmem_rdata,
  output word_t     o_mem_fwd,
  output logic      o_wb_we,
  output reg_addr_t o_wb_rd,
  output word_t     o_wb_data,
  output reg_addr_t o_mem_wb_rd,
  output logic      o_mem_wb_we
);

  mem_wb_t mem_wb;

  // Data memory request, written on the next rising edge
  assign o_dmem_req.we    = i_ex_mem.valid && i_ex_mem.mem_write;
  assign o_dmem_req.addr  = i_ex_mem.alu_result;
  assign o_dmem_req.wdata = i_ex_mem.store_data;

  // Load data is not ready here, loads forward from writeback
  assign o_mem_fwd = (i_ex_mem.wb_sel == WB_PC4) ? i_ex_mem.pc4 : i_ex_mem.alu_result;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid      <= i_ex_mem.valid;
      mem_wb.alu_result <= i_ex_mem.alu_result;
      mem_wb.load_data  <= i_dmem_rdata;
      mem_wb.pc4        <= i_ex_mem.pc4;
      mem_wb.rd         <= i_ex_mem.rd;
      mem_wb.reg_we     <= i_ex_mem.reg_we;
      mem_wb.wb_sel     <= i_ex_mem.wb_sel;
    end
  end

  always_comb begin
    case (mem_wb.wb_sel)
      WB_LOAD: o_wb_data = mem_wb.load_data;
      WB_PC4:  o_wb_data = mem_wb.pc4;
      default: o_wb_data = mem_wb.alu_result;
    endcase
  end

  assign o_wb_we = mem_wb.valid && mem_wb.reg_we;
  assign o_wb_rd = mem_wb.rd;

  // Forwarding view, a write to x0 is never a source
  assign o_mem_wb_we = o_wb_we && (mem_wb.rd != '0);
  assign o_mem_wb_rd = mem_wb.rd;

  a_store_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_dmem_req.we |-> o_dmem_req.addr[1:0] == 2'b00);

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file
  import rv_core_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_we,
  input  reg_addr_t i_waddr,
  input  word_t     i_wdata,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  word_t regs [NUM_REGS];
  logic  wr_en;

  // x0 is never written
  assign wr_en = i_we && (i_waddr != '0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Same-cycle write is seen by the reads
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      (wr_en && i_waddr == i_rs1_addr) ? i_wdata : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      (wr_en && i_waddr == i_rs2_addr) ? i_wdata : regs[i_rs2_addr];

  a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n) regs[0] == '0);

endmodule

//--- hw/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [31:0]                 inst_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // BR_JUMP is unconditional, used by JAL and JALR
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP
  } br_op_e;

  typedef enum logic {A_RS1, A_PC} alu_a_sel_e;
  typedef enum logic {B_RS2, B_IMM} alu_b_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } if_id_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       reg_we;
    logic       mem_read;
    logic       mem_write;
    alu_op_e    alu_op;
    alu_a_sel_e a_sel;
    alu_b_sel_e b_sel;
    br_op_e     br_op;
    wb_sel_e    wb_sel;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     alu_result;
    word_t     store_data;
    word_t     pc4;
    reg_addr_t rd;
    logic      reg_we;
    logic      mem_read;
    logic      mem_write;
    wb_sel_e   wb_sel;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    word_t     alu_result;
    word_t     load_data;
    word_t     pc4;
    reg_addr_t rd;
    logic      reg_we;
    wb_sel_e   wb_sel;
  } mem_wb_t;

  typedef struct packed {
    logic  we;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

//--- hw/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic      i_clk,
  input  logic      i_rst_n,

  output word_t     o_imem_addr,
  input  inst_t     i_imem_rdata,

  output dmem_req_t o_dmem_req,
  input  word_t     i_dmem_rdata
);

  // Stage registers
  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;

  // Control transfer and hazard control
  logic      redirect;
  word_t     target;
  logic      stall;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;

  // Register file access
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // Writeback and forwarding values
  word_t     mem_fwd;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      mem_wb_we;
  reg_addr_t mem_wb_rd;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) fetch_stage_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_stall      (stall),
    .i_redirect   (redirect),
    .i_target     (target),
    .o_imem_addr  (o_imem_addr),
    .i_imem_rdata (i_imem_rdata),
    .o_if_id      (if_id)
  );

  decode_stage decode_stage_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_if_id    (if_id),
    .i_stall    (stall),
    .i_redirect (redirect),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_id_ex    (id_ex)
  );

  register_file register_file_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_we       (wb_we),
    .i_waddr    (wb_rd),
    .i_wdata    (wb_data),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  execute_stage execute_stage_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_id_ex    (id_ex),
    .i_fwd_a    (fwd_a),
    .i_fwd_b    (fwd_b),
    .i_mem_fwd  (mem_fwd),
    .i_wb_fwd   (wb_data),
    .o_redirect (redirect),
    .o_target   (target),
    .o_ex_mem   (ex_mem)
  );

  memory_stage memory_stage_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_ex_mem     (ex_mem),
    .o_dmem_req   (o_dmem_req),
    .i_dmem_rdata (i_dmem_rdata),
    .o_mem_fwd    (mem_fwd),
    .o_wb_we      (wb_we),
    .o_wb_rd      (wb_rd),
    .o_wb_data    (wb_data),
    .o_mem_wb_rd  (mem_wb_rd),
    .o_mem_wb_we  (mem_wb_we)
  );

  hazard_unit hazard_unit_inst (
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .i_id_ex    (id_ex),
    .i_ex_mem   (ex_mem),
    .i_wb_we    (mem_wb_we),
    .i_wb_rd    (mem_wb_rd),
    .o_stall    (stall),
    .o_fwd_a    (fwd_a),
    .o_fwd_b    (fwd_b)
  );

endmodule
